// ==== Bender.yml ====
package:
  name: flat_shader

sources:
  - common/shader_pkg.sv
  - normal/face_normal.sv
  - design/cos_sq_divider.sv
  - design/shade_lut.sv
  - design/flat_shader.sv
  - target: test
    files:
      - tests/flat_shader_tb.sv

// ==== common/shader_pkg.sv ====
package shader_pkg;

    // vertex coordinate width, everything below is sized from it
    localparam int coord_w = 12;

    typedef logic signed [coord_w-1:0] coord_t;

    // x in [0], y in [1], z in [2]
    typedef coord_t [2:0] vertex_t;

    // difference of two coordinates needs one extra bit
    typedef logic signed [coord_w:0] edge_t;

    // difference of two edge products
    typedef logic signed [2*coord_w+2:0] normal_t;

    // square of one normal component, always non-negative
    typedef logic [2*(2*coord_w+3)-1:0] square_t;

    // sum of three squares, two bits of growth
    typedef logic [2*(2*coord_w+3)+1:0] mag_t;

    typedef logic [3:0] shade_idx_t;
    typedef logic [7:0] color_t;

    // cycles through each pipeline block
    localparam int normal_latency = 3;
    localparam int divide_latency = 5;
    localparam int lut_latency    = 1;
    localparam int shader_latency = normal_latency + divide_latency + lut_latency;

    // a face turned away from the light is drawn white
    localparam color_t away_color = 8'd255;

    // falloff curve indexed by floor(16 * cos^2)
    localparam color_t shade_table [16] = '{
        8'd0,   8'd20,  8'd40,  8'd60,
        8'd78,  8'd96,  8'd114, 8'd130,
        8'd146, 8'd162, 8'd178, 8'd194,
        8'd210, 8'd226, 8'd242, 8'd255
    };

endpackage

// ==== design/cos_sq_divider.sv ====
`timescale 1ns/1ps

module cos_sq_divider (
    input  logic                   clk,
    input  logic                   rst_in,
    input  logic                   norm_valid,
    input  shader_pkg::square_t    nz_sq,
    input  shader_pkg::mag_t       mag_sq,
    input  logic                   away,
    output logic                   idx_valid,
    output shader_pkg::shade_idx_t shade_idx,
    output logic                   idx_away
);

    localparam int last = shader_pkg::divide_latency - 1;

    // one spare bit so a doubled remainder never overflows
    typedef logic [$bits(shader_pkg::mag_t):0] wide_t;

    // registers between steps, the last step writes the outputs directly
    shader_pkg::mag_t rem_q [last];
    shader_pkg::mag_t den_q [last];
    logic [4:0]       quo_q [last];
    logic             vld_q [last];
    logic             awy_q [last];

    // per-step compare and subtract
    wide_t            trial    [shader_pkg::divide_latency];
    wide_t            den_in   [shader_pkg::divide_latency];
    wide_t            rem_next [shader_pkg::divide_latency];
    logic             take     [shader_pkg::divide_latency];
    logic [4:0]       quotient;

    always_comb begin
        // first step weighs 16, nz_sq never exceeds mag_sq so no doubling yet
        trial[0] = '0;
        trial[0][$bits(shader_pkg::square_t)-1:0] = nz_sq;
        den_in[0] = {1'b0, mag_sq};
        for (int s = 1; s < shader_pkg::divide_latency; s++) begin
            trial[s]  = {rem_q[s-1], 1'b0};
            den_in[s] = {1'b0, den_q[s-1]};
        end
        for (int s = 0; s < shader_pkg::divide_latency; s++) begin
            take[s]     = trial[s] >= den_in[s];
            rem_next[s] = take[s] ? trial[s] - den_in[s] : trial[s];
        end
        quotient = {quo_q[last-1][3:0], take[last]};
    end

    always_ff @(posedge clk) begin
        if (rst_in) begin
            for (int s = 0; s < last; s++) begin
                vld_q[s] <= 1'b0;
            end
            idx_valid <= 1'b0;
        end else begin
            vld_q[0] <= norm_valid;
            for (int s = 1; s < last; s++) begin
                vld_q[s] <= vld_q[s-1];
            end
            idx_valid <= vld_q[last-1];
        end
    end

    always_ff @(posedge clk) begin
        rem_q[0] <= rem_next[0][$bits(shader_pkg::mag_t)-1:0];
        den_q[0] <= mag_sq;
        quo_q[0] <= {4'b0000, take[0]};
        awy_q[0] <= away;
        for (int s = 1; s < last; s++) begin
            // remainder stays below the divisor so the top bit is always clear
            rem_q[s] <= rem_next[s][$bits(shader_pkg::mag_t)-1:0];
            den_q[s] <= den_q[s-1];
            quo_q[s] <= {quo_q[s-1][3:0], take[s]};
            awy_q[s] <= awy_q[s-1];
        end
        idx_away <= awy_q[last-1];
        // zero normal has no direction, a quotient of 16 is a face square to the light
        if (den_q[last-1] == '0) begin
            shade_idx <= '0;
        end else if (quotient[4]) begin
            shade_idx <= 4'd15;
        end else begin
            shade_idx <= quotient[3:0];
        end
    end

endmodule

// ==== design/flat_shader.sv ====
`timescale 1ns/1ps

module flat_shader (
    input  logic                clk,
    input  logic                rst_in,
    input  logic                data_valid_in,
    input  shader_pkg::vertex_t vert0,
    input  shader_pkg::vertex_t vert1,
    input  shader_pkg::vertex_t vert2,
    output logic                valid_out,
    output shader_pkg::color_t  color
);

    // face_normal to divider
    logic                  norm_valid;
    shader_pkg::square_t   nz_sq;
    shader_pkg::mag_t      mag_sq;
    logic                  away;

    // divider to table
    logic                  idx_valid;
    shader_pkg::shade_idx_t shade_idx;
    logic                  idx_away;

    face_normal u_face_normal (
        .clk           (clk),
        .rst_in        (rst_in),
        .data_valid_in (data_valid_in),
        .vert0         (vert0),
        .vert1         (vert1),
        .vert2         (vert2),
        .norm_valid    (norm_valid),
        .nz_sq         (nz_sq),
        .mag_sq        (mag_sq),
        .away          (away)
    );

    cos_sq_divider u_cos_sq_divider (
        .clk        (clk),
        .rst_in     (rst_in),
        .norm_valid (norm_valid),
        .nz_sq      (nz_sq),
        .mag_sq     (mag_sq),
        .away       (away),
        .idx_valid  (idx_valid),
        .shade_idx  (shade_idx),
        .idx_away   (idx_away)
    );

    shade_lut u_shade_lut (
        .clk       (clk),
        .rst_in    (rst_in),
        .idx_valid (idx_valid),
        .shade_idx (shade_idx),
        .idx_away  (idx_away),
        .valid_out (valid_out),
        .color     (color)
    );

endmodule

// ==== design/shade_lut.sv ====
`timescale 1ns/1ps

module shade_lut (
    input  logic                   clk,
    input  logic                   rst_in,
    input  logic                   idx_valid,
    input  shader_pkg::shade_idx_t shade_idx,
    input  logic                   idx_away,
    output logic                   valid_out,
    output shader_pkg::color_t     color
);

    shader_pkg::color_t next_color;

    // back faces skip the table
    always_comb begin
        if (idx_away) begin
            next_color = shader_pkg::away_color;
        end else begin
            next_color = shader_pkg::shade_table[shade_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_in) begin
            valid_out <= 1'b0;
            color     <= '0;
        end else begin
            valid_out <= idx_valid;
            // hold the last color between results
            if (idx_valid) begin
                color <= next_color;
            end
        end
    end

endmodule

// ==== normal/face_normal.sv ====
`timescale 1ns/1ps

module face_normal (
    input  logic                clk,
    input  logic                rst_in,
    input  logic                data_valid_in,
    input  shader_pkg::vertex_t vert0,
    input  shader_pkg::vertex_t vert1,
    input  shader_pkg::vertex_t vert2,
    output logic                norm_valid,
    output shader_pkg::square_t nz_sq,
    output shader_pkg::mag_t    mag_sq,
    output logic                away
);

    // stage 1: edges from vertex 0, edge_a = (d, e, f), edge_b = (g, h, i)
    shader_pkg::edge_t   edge_a [3];
    shader_pkg::edge_t   edge_b [3];
    logic                edge_valid;

    // stage 2: cross product
    shader_pkg::normal_t nrm [3];
    logic                nrm_valid;

    // squares of each component, registered as a sum in stage 3
    shader_pkg::square_t sq [3];

    always_ff @(posedge clk) begin
        if (rst_in) begin
            edge_valid <= 1'b0;
            nrm_valid  <= 1'b0;
            norm_valid <= 1'b0;
        end else begin
            edge_valid <= data_valid_in;
            nrm_valid  <= edge_valid;
            norm_valid <= nrm_valid;
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < 3; k++) begin
            edge_a[k] <= signed'(vert1[k]) - signed'(vert0[k]);
            edge_b[k] <= signed'(vert2[k]) - signed'(vert0[k]);
        end
    end

    // nx = ei - fh, ny = fg - di, nz = dh - eg
    always_ff @(posedge clk) begin
        nrm[0] <= edge_a[1] * edge_b[2] - edge_a[2] * edge_b[1];
        nrm[1] <= edge_a[2] * edge_b[0] - edge_a[0] * edge_b[2];
        nrm[2] <= edge_a[0] * edge_b[1] - edge_a[1] * edge_b[0];
    end

    // operands are signed so the products sign-extend to the full square width
    always_comb begin
        for (int k = 0; k < 3; k++) begin
            sq[k] = nrm[k] * nrm[k];
        end
    end

    always_ff @(posedge clk) begin
        nz_sq  <= sq[2];
        mag_sq <= sq[0] + sq[1] + sq[2];
        // negative z means the face looks the same way as the light
        away   <= nrm[2][$bits(shader_pkg::normal_t)-1];
    end

endmodule

// ==== src.f ====
common/shader_pkg.sv
normal/face_normal.sv
design/cos_sq_divider.sv
design/shade_lut.sv
design/flat_shader.sv
tests/flat_shader_tb.sv

// ==== tests/flat_shader_tb.sv ====
`timescale 1ns/1ps

module flat_shader_tb;

    localparam int reset_cycles    = 10;
    localparam int random_count    = 200;
    localparam int burst_count     = 64;
    localparam int directed_count  = 5;
    localparam int total_strobes   = random_count + burst_count + directed_count;
    localparam int watchdog_cycles =
        (reset_cycles + total_strobes + shader_pkg::shader_latency + 20) * 2;

    logic                clk = 1'b0;
    logic                rst_in;
    logic                data_valid_in;
    shader_pkg::vertex_t vert0;
    shader_pkg::vertex_t vert1;
    shader_pkg::vertex_t vert2;
    logic                valid_out;
    shader_pkg::color_t  color;

    logic [31:0] rng_state = 32'h69458025;
    string       current_test = "reset";

    // expected results in arrival order and the test that sent each one
    shader_pkg::color_t expected_q [$];
    string              name_q [$];

    // strobe history where the oldest bit is the strobe due at the output now
    logic [shader_pkg::shader_latency-1:0] strobe_pipe = '0;

    int color_errors = 0;
    int valid_errors = 0;
    int other_errors = 0;

    flat_shader dut (
        .clk           (clk),
        .rst_in        (rst_in),
        .data_valid_in (data_valid_in),
        .vert0         (vert0),
        .vert1         (vert1),
        .vert2         (vert2),
        .valid_out     (valid_out),
        .color         (color)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic longint coord_of(input shader_pkg::vertex_t v, input int k);
        shader_pkg::coord_t c;
        c = v[k];
        return longint'(c);
    endfunction

    function automatic shader_pkg::vertex_t make_vertex(input int x, input int y, input int z);
        shader_pkg::vertex_t v;
        v[0] = shader_pkg::coord_t'(x);
        v[1] = shader_pkg::coord_t'(y);
        v[2] = shader_pkg::coord_t'(z);
        return v;
    endfunction

    // shading rules worked out in wide integers
    function automatic shader_pkg::color_t expected_color(input shader_pkg::vertex_t v0,
                                                          input shader_pkg::vertex_t v1,
                                                          input shader_pkg::vertex_t v2);
        longint d, e, f, g, h, i;
        longint nx, ny, nz, nz2, mag, idx;
        d = coord_of(v1, 0) - coord_of(v0, 0);
        e = coord_of(v1, 1) - coord_of(v0, 1);
        f = coord_of(v1, 2) - coord_of(v0, 2);
        g = coord_of(v2, 0) - coord_of(v0, 0);
        h = coord_of(v2, 1) - coord_of(v0, 1);
        i = coord_of(v2, 2) - coord_of(v0, 2);
        nx = e * i - f * h;
        ny = f * g - d * i;
        nz = d * h - e * g;
        if (nz < 0) begin
            return shader_pkg::away_color;
        end
        nz2 = nz * nz;
        mag = nx * nx + ny * ny + nz2;
        if (mag == 0) begin
            idx = 0;
        end else begin
            idx = (16 * nz2) / mag;
        end
        if (idx > 15) begin
            idx = 15;
        end
        return shader_pkg::shade_table[idx];
    endfunction

    task automatic check_color(input string name, input shader_pkg::color_t expected,
                               input shader_pkg::color_t actual);
        if (actual !== expected) begin
            $display("error: test %s color expected %0d actual %0d", name, expected, actual);
            color_errors++;
        end
    endtask

    task automatic check_valid(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error: test %s valid_out expected %b actual %b", name, expected, actual);
            valid_errors++;
        end
    endtask

    task automatic random_vertex(output shader_pkg::vertex_t v);
        rng_state = xorshift32(rng_state);
        v[0] = rng_state[11:0];
        v[1] = rng_state[23:12];
        rng_state = xorshift32(rng_state);
        v[2] = rng_state[11:0];
    endtask

    task automatic send_triangle(input string name, input shader_pkg::vertex_t v0,
                                 input shader_pkg::vertex_t v1, input shader_pkg::vertex_t v2);
        @(posedge clk);
        current_test  = name;
        data_valid_in <= 1'b1;
        vert0         <= v0;
        vert1         <= v1;
        vert2         <= v2;
    endtask

    task automatic send_idle();
        @(posedge clk);
        data_valid_in <= 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < 2 * shader_pkg::shader_latency) begin
            @(posedge clk);
            waited++;
        end
    endtask

    // outputs are sampled half a cycle away from the driving edge
    always @(negedge clk) begin
        check_valid(current_test, strobe_pipe[shader_pkg::shader_latency-1], valid_out);
        strobe_pipe = {strobe_pipe[shader_pkg::shader_latency-2:0], data_valid_in};
        if (current_test == "reset") begin
            check_color("reset", '0, color);
        end
        if (valid_out === 1'b1) begin
            if (expected_q.size() == 0) begin
                $display("result with color %0d arrived with no triangle outstanding", color);
                other_errors++;
            end else begin
                check_color(name_q.pop_front(), expected_q.pop_front(), color);
            end
        end
        if (data_valid_in) begin
            expected_q.push_back(expected_color(vert0, vert1, vert2));
            name_q.push_back(current_test);
        end
    end

    initial begin
        #(watchdog_cycles * 100);
        $display("timeout after %0d cycles, the run did not complete", watchdog_cycles);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        shader_pkg::vertex_t a, b, c;
        int sent;
        rst_in        = 1'b1;
        data_valid_in = 1'b0;
        vert0         = '0;
        vert1         = '0;
        vert2         = '0;

        repeat (reset_cycles) @(posedge clk);
        rst_in <= 1'b0;
        repeat (3) @(posedge clk);

        // about one strobe in two cycles
        current_test = "random";
        sent = 0;
        while (sent < random_count) begin
            rng_state = xorshift32(rng_state);
            if (rng_state[31]) begin
                random_vertex(a);
                random_vertex(b);
                random_vertex(c);
                send_triangle("random", a, b, c);
                sent++;
            end else begin
                send_idle();
            end
        end
        send_idle();
        wait_drain();

        // one triangle per cycle back to back
        current_test = "burst";
        for (int k = 0; k < burst_count; k++) begin
            random_vertex(a);
            random_vertex(b);
            random_vertex(c);
            send_triangle("burst", a, b, c);
        end
        send_idle();
        wait_drain();

        // flat in z so the normal points along +z and the index saturates to 15
        a = make_vertex(10, 20, 5);
        b = make_vertex(110, 20, 5);
        c = make_vertex(10, 120, 5);
        check_color("facing model", 8'd255, expected_color(a, b, c));
        send_triangle("facing", a, b, c);

        check_color("backface model", shader_pkg::away_color, expected_color(a, c, b));
        send_triangle("backface", a, c, b);

        // tilted back face where the table alone would give a mid grey
        a = make_vertex(0, 0, 0);
        b = make_vertex(0, 100, 0);
        c = make_vertex(100, 0, 100);
        check_color("backface tilted model", shader_pkg::away_color, expected_color(a, b, c));
        send_triangle("backface_tilted", a, b, c);

        // normal lies in the xy plane
        a = make_vertex(0, 0, 0);
        b = make_vertex(100, 0, 0);
        c = make_vertex(0, 0, 100);
        check_color("edge_on model", 8'd0, expected_color(a, b, c));
        send_triangle("edge_on", a, b, c);

        a = make_vertex(37, -12, 900);
        check_color("degenerate model", 8'd0, expected_color(a, a, a));
        send_triangle("degenerate", a, a, a);
        send_idle();
        wait_drain();

        // idle tail so a stray valid_out is still caught
        current_test = "idle";
        repeat (shader_pkg::shader_latency + 2) @(posedge clk);
        if (expected_q.size() != 0) begin
            $display("%0d expected results never came out", expected_q.size());
            other_errors++;
        end

        $display("color errors: %0d, valid errors: %0d, other errors: %0d",
                 color_errors, valid_errors, other_errors);
        if (color_errors + valid_errors + other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
